// File: compile.f
+incdir+dv
rtl/ik_pkg.sv
rtl/ik_reg_file.sv
rtl/sincos.sv
rtl/jacobian_seq.sv
rtl/jjt_accum.sv
rtl/ik_swift_top.sv
dv/ik_swift_tb.sv

// File: Makefile
# Verilator build and run of the planar IK accelerator testbench.
# The run passes only if the log holds the pass message.

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module ik_swift_tb \
		-f compile.f -o sim_ik
	./obj_dir/sim_ik | tee sim.log
	@if grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: dv/ik_ref_model.svh
//////////////////////////////////////////////////////////////////////
// Reference model for the IK testbench. Keeps an image of the host
// registers as written and predicts the published result grid from
// it with the Q8 rules. Included inside the testbench module.
//////////////////////////////////////////////////////////////////////

`ifndef IK_REF_MODEL_SVH
`define IK_REF_MODEL_SVH

typedef logic signed [ik_pkg::WORD_W-1:0] word_t;

// register image kept in step with accepted host writes
word_t mdl_target_x, mdl_target_y, mdl_damping;
logic [ik_pkg::NUM_JOINTS-1:0] mdl_joint_type;
word_t mdl_theta [ik_pkg::NUM_JOINTS];
word_t mdl_length [ik_pkg::NUM_JOINTS];

word_t exp_grid [3][4]; // rows 0..2, cols 0..3

// full product, arithmetic shift, wrap to a word
function automatic word_t q8_mul(input word_t a, input word_t b);
	longint full;
	full = longint'(a) * longint'(b);
	return word_t'(full >>> ik_pkg::FRAC_W);
endfunction

function automatic word_t insert_byte(input word_t w, input logic [1:0] lane,
	input logic [7:0] wd);
	word_t r;
	r = w;
	case (lane)
		2'd0:    r[ik_pkg::WORD_W-1:24] = wd[2:0]; // top byte holds 3 bits
		2'd1:    r[23:16] = wd;
		2'd2:    r[15:8] = wd;
		default: r[7:0] = wd;
	endcase
	return r;
endfunction

function automatic void store_byte(input logic [6:0] addr, input logic [7:0] wd);
	logic [6:0] off;
	int j;
	off = addr - ik_pkg::ADDR_JOINT_BASE;
	j = int'(off / ik_pkg::JOINT_STRIDE);
	if (addr < ik_pkg::ADDR_TARGET_Y)
		mdl_target_x = insert_byte(mdl_target_x, 2'(addr - ik_pkg::ADDR_TARGET_X), wd);
	else if (addr < ik_pkg::ADDR_JOINT_TYPE)
		mdl_target_y = insert_byte(mdl_target_y, 2'(addr - ik_pkg::ADDR_TARGET_Y), wd);
	else if (addr == ik_pkg::ADDR_JOINT_TYPE)
		mdl_joint_type = wd[ik_pkg::NUM_JOINTS-1:0];
	else if (addr < ik_pkg::ADDR_JOINT_BASE)
		mdl_damping = insert_byte(mdl_damping, 2'(addr - ik_pkg::ADDR_DAMPING), wd);
	else if (off[2])
		mdl_length[j] = insert_byte(mdl_length[j], off[1:0], wd);
	else
		mdl_theta[j] = insert_byte(mdl_theta[j], off[1:0], wd);
endfunction

function automatic void clear_model();
	mdl_target_x = '0;
	mdl_target_y = '0;
	mdl_damping = '0;
	mdl_joint_type = '0;
	foreach (mdl_theta[j]) begin
		mdl_theta[j] = '0;
		mdl_length[j] = '0;
	end
endfunction

// taylor sine and cosine of a binary angle, then quadrant fold
function automatic void trig_q8(input logic [ik_pkg::ANGLE_W-1:0] ang,
	output word_t s_out, output word_t c_out);
	word_t x, x2, x3, x4, x5, s, c;
	x = q8_mul(word_t'(ang[ik_pkg::ANGLE_W-3:0]), ik_pkg::HALF_PI_Q8);
	x2 = q8_mul(x, x);
	x3 = q8_mul(x2, x);
	x4 = q8_mul(x3, x);
	x5 = q8_mul(x4, x);
	s = x - q8_mul(x3, ik_pkg::INV6_Q8) + q8_mul(x5, ik_pkg::INV120_Q8);
	c = ik_pkg::ONE_Q8 - (x2 >>> 1) + q8_mul(x4, ik_pkg::INV24_Q8);
	case (ang[ik_pkg::ANGLE_W-1 -: 2])
		2'd0: begin
			s_out = s;
			c_out = c;
		end
		2'd1: begin
			s_out = c;
			c_out = -s;
		end
		2'd2: begin
			s_out = -s;
			c_out = -c;
		end
		default: begin
			s_out = -c;
			c_out = s;
		end
	endcase
endfunction

function automatic void predict_grid();
	word_t cs [ik_pkg::NUM_JOINTS];
	word_t sn [ik_pkg::NUM_JOINTS];
	word_t px [ik_pkg::NUM_JOINTS+1];
	word_t py [ik_pkg::NUM_JOINTS+1];
	word_t cx, cy, sxx, sxy, syy;
	logic [ik_pkg::ANGLE_W-1:0] sum;
	sum = '0;
	px[0] = '0;
	py[0] = '0;
	for (int i = 0; i < ik_pkg::NUM_JOINTS; i++) begin
		sum = sum + mdl_theta[i][ik_pkg::ANGLE_W-1:0]; // wraps at one turn
		trig_q8(sum, sn[i], cs[i]);
		px[i+1] = px[i] + q8_mul(mdl_length[i], cs[i]);
		py[i+1] = py[i] + q8_mul(mdl_length[i], sn[i]);
	end
	sxx = '0;
	sxy = '0;
	syy = '0;
	for (int i = 0; i < ik_pkg::NUM_JOINTS; i++) begin
		if (mdl_joint_type[i]) begin
			cx = -(py[ik_pkg::NUM_JOINTS] - py[i]);
			cy = px[ik_pkg::NUM_JOINTS] - px[i];
		end else begin
			cx = cs[i];
			cy = sn[i];
		end
		sxx = sxx + q8_mul(cx, cx);
		sxy = sxy + q8_mul(cx, cy);
		syy = syy + q8_mul(cy, cy);
	end
	foreach (exp_grid[r, c])
		exp_grid[r][c] = '0;
	exp_grid[0][0] = sxx + mdl_damping;
	exp_grid[0][1] = sxy;
	exp_grid[1][0] = sxy;
	exp_grid[1][1] = syy + mdl_damping;
	exp_grid[2][0] = mdl_target_x - px[ik_pkg::NUM_JOINTS];
	exp_grid[2][1] = mdl_target_y - py[ik_pkg::NUM_JOINTS];
endfunction

`endif

// File: dv/ik_swift_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the planar IK accelerator. Loads arms from a table
// over the byte bus, waits for two done pulses and reads back the
// whole result grid against the reference model.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ik_swift_tb;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int N_FIXED = 5;
	localparam int N_RANDOM = 6;
	localparam int N_ROWS = N_FIXED + N_RANDOM;
	localparam int N_PHASES = N_ROWS + 2; // reset and byte lane phases too
	localparam int DONE_TIMEOUT = 2 * ik_pkg::FRAME_CYCLES;
	localparam longint WATCHDOG_NS = longint'(N_PHASES)
		* (61 + 3 * ik_pkg::FRAME_CYCLES + 12) * CLK_PERIOD * 2;

	logic clk, reset, chipselect, write, done;
	logic [6:0] address;
	logic [7:0] writedata;
	logic [2:0] row_select, col_select;
	logic [ik_pkg::WORD_W-1:0] data;

	`include "ik_ref_model.svh"

	// one arm per row
	logic [31:0] tab_theta [N_ROWS][ik_pkg::NUM_JOINTS];
	logic [31:0] tab_len [N_ROWS][ik_pkg::NUM_JOINTS];
	logic [7:0] tab_jtype [N_ROWS];
	logic [31:0] tab_damp [N_ROWS];
	logic [31:0] tab_tx [N_ROWS];
	logic [31:0] tab_ty [N_ROWS];

	ik_swift_top ik_swift_top_inst (
		.clk, .reset, .chipselect, .write, .address, .writedata,
		.row_select, .col_select, .data, .done
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic bus_write(input logic [6:0] addr, input logic [7:0] wd,
		input logic cs, input logic wr);
		chipselect = cs;
		write = wr;
		address = addr;
		writedata = wd;
		if (cs && wr && addr <= ik_pkg::ADDR_LAST)
			store_byte(addr, wd);
		next_cycle();
		chipselect = 1'b0;
		write = 1'b0;
	endtask

	task automatic write_word(input logic [6:0] base, input logic [31:0] value);
		for (int k = 0; k < 4; k++)
			bus_write(7'(base + k), value[31 - 8 * k -: 8], 1'b1, 1'b1); // top byte first
	endtask

	task automatic load_arm(input int row);
		write_word(ik_pkg::ADDR_TARGET_X, tab_tx[row]);
		write_word(ik_pkg::ADDR_TARGET_Y, tab_ty[row]);
		bus_write(ik_pkg::ADDR_JOINT_TYPE, tab_jtype[row], 1'b1, 1'b1);
		write_word(ik_pkg::ADDR_DAMPING, tab_damp[row]);
		for (int j = 0; j < ik_pkg::NUM_JOINTS; j++) begin
			write_word(7'(ik_pkg::ADDR_JOINT_BASE + j * ik_pkg::JOINT_STRIDE),
				tab_theta[row][j]);
			write_word(7'(ik_pkg::ADDR_JOINT_BASE + j * ik_pkg::JOINT_STRIDE + 4),
				tab_len[row][j]);
		end
	endtask

	task automatic wait_done(input int n);
		int seen;
		int cycles;
		int last_done;
		seen = 0;
		cycles = 0;
		last_done = 0;
		while (seen < n) begin
			next_cycle();
			cycles++;
			if (done === 1'b1) begin
				if (seen > 0) begin
					assert (cycles - last_done == ik_pkg::FRAME_CYCLES) else begin
						$display("done pulses came %0d cycles apart instead of one frame",
							cycles - last_done);
						abort_run();
					end
				end
				seen++;
				last_done = cycles;
			end
			assert (cycles <= n * DONE_TIMEOUT) else begin
				$display("done did not pulse %0d times within %0d cycles",
					n, n * DONE_TIMEOUT);
				abort_run();
			end
		end
		next_cycle(); // grid latches on the edge after done
	endtask

	task automatic sweep_grid(input logic expect_idle);
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 4; c++) begin
				row_select = 3'(r);
				col_select = 3'(c);
				next_cycle();
				assert (data === exp_grid[r][c]) else begin
					$display("error: data at row %0d col %0d expected %h got %h",
						r, c, exp_grid[r][c], data);
					abort_run();
				end
				if (expect_idle) begin
					assert (done === 1'b0) else begin
						$display("done pulsed before the first frame could have ended");
						abort_run();
					end
				end
			end
		end
	endtask

	task automatic fill_table();
		// rotational chain whose sums cross all quadrants and wrap past 1024
		tab_theta[0] = '{32'h64, 32'h12C, 32'hFA, 32'hF80010C8, 32'h96, 32'h5A};
		tab_len[0] = '{32'h100, 32'hC0, 32'h180, 32'h80, 32'h200, 32'h140};
		tab_jtype[0] = 8'h3F;
		tab_damp[0] = 32'h20;
		tab_tx[0] = 32'h300;
		tab_ty[0] = 32'hFFFFFE80;
		// all translational
		tab_theta[1] = '{32'h0, 32'h100, 32'h100, 32'h100, 32'h25, 32'h3C1};
		tab_len[1] = '{32'h100, 32'h100, 32'h80, 32'h200, 32'h300, 32'h40};
		tab_jtype[1] = 8'h00;
		tab_damp[1] = 32'h100;
		tab_tx[1] = 32'h0;
		tab_ty[1] = 32'h80;
		// mixed types with the unused bits 7:6 of the type byte set
		tab_theta[2] = '{32'h3F0, 32'h2A, 32'h155, 32'h200, 32'h1FF, 32'h301};
		tab_len[2] = '{32'h1C0, 32'h90, 32'h3FF, 32'h10, 32'h250, 32'h120};
		tab_jtype[2] = 8'hD5;
		tab_damp[2] = 32'h0;
		tab_tx[2] = 32'hFFFFFF00;
		tab_ty[2] = 32'h200;
		tab_theta[3] = '{32'h200, 32'h200, 32'h1, 32'h3FF, 32'h180, 32'h80};
		tab_len[3] = '{32'h400, 32'h400, 32'h400, 32'h400, 32'h400, 32'h400};
		tab_jtype[3] = 8'h2A;
		tab_damp[3] = 32'h7FFF;
		tab_tx[3] = 32'h1800;
		tab_ty[3] = 32'hFFFFE800;
		// top bytes with bits above 2 set
		tab_theta[4] = '{32'hFFFFFFFF, 32'h0, 32'hF8000155, 32'h0, 32'h2FF, 32'h0};
		tab_len[4] = '{32'hF8000100, 32'h0, 32'hF8000200, 32'h0, 32'h100, 32'h0};
		tab_jtype[4] = 8'h3F;
		tab_damp[4] = 32'h1;
		tab_tx[4] = 32'h07000000;
		tab_ty[4] = 32'h00FFFFFF;
		for (int r = N_FIXED; r < N_ROWS; r++) begin
			for (int j = 0; j < ik_pkg::NUM_JOINTS; j++) begin
				tab_theta[r][j] = $urandom;
				tab_len[r][j] = $urandom_range(1024); // at most 4.0
			end
			tab_jtype[r] = 8'($urandom);
			tab_damp[r] = $urandom_range(512);
			tab_tx[r] = $urandom;
			tab_ty[r] = $urandom;
		end
	endtask

	task automatic probe_byte_lanes();
		bus_write(7'(ik_pkg::ADDR_TARGET_X + 3), 8'h5A, 1'b1, 1'b1); // low byte only
		bus_write(7'(ik_pkg::ADDR_JOINT_BASE + 2 * ik_pkg::JOINT_STRIDE + 7), 8'h33,
			1'b1, 1'b1);
		bus_write(ik_pkg::ADDR_DAMPING, 8'hFF, 1'b1, 1'b1);
		bus_write(7'(ik_pkg::ADDR_TARGET_Y + 1), 8'h12, 1'b0, 1'b1); // no chipselect
		bus_write(7'(ik_pkg::ADDR_TARGET_Y + 2), 8'h34, 1'b1, 1'b0);
		bus_write(7'd61, 8'hFF, 1'b1, 1'b1);
		bus_write(7'd100, 8'h80, 1'b1, 1'b1);
		bus_write(7'd127, 8'h7F, 1'b1, 1'b1);
		wait_done(2);
		predict_grid();
		sweep_grid(1'b0);
	endtask

	initial begin
		void'($urandom(32'haf659059));
		reset = 1'b1;
		chipselect = 1'b0;
		write = 1'b0;
		address = '0;
		writedata = '0;
		row_select = '0;
		col_select = '0;
		clear_model();
		fill_table();
		repeat (5) next_cycle();
		reset = 1'b0;

		// nothing published yet
		foreach (exp_grid[r, c])
			exp_grid[r][c] = '0;
		sweep_grid(1'b1);
		wait_done(1);
		predict_grid();
		sweep_grid(1'b0);

		for (int row = 0; row < N_ROWS; row++) begin
			load_arm(row);
			wait_done(2);
			predict_grid();
			sweep_grid(1'b0);
		end

		probe_byte_lanes();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: rtl/ik_swift_top.sv
//////////////////////////////////////////////////////////////////////
// Top level of the planar IK accelerator. Host bytes go into the
// register file; results are read back by row_select and col_select.
// done pulses once per frame when a new grid is published.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ik_swift_top (
	input  logic clk,
	input  logic reset,

	input  logic chipselect,
	input  logic write,
	input  logic [6:0] address,
	input  logic [7:0] writedata,

	input  logic [2:0] row_select,
	input  logic [2:0] col_select,
	output logic [ik_pkg::WORD_W-1:0] data,
	output logic done
);

	logic [ik_pkg::WORD_W-1:0] target_x, target_y, damping;
	logic [ik_pkg::NUM_JOINTS-1:0] joint_type;
	logic [ik_pkg::NUM_JOINTS-1:0][ik_pkg::WORD_W-1:0] theta, length;

	logic [ik_pkg::ANGLE_W-1:0] angle;
	logic angle_valid, trig_valid;
	logic signed [ik_pkg::WORD_W-1:0] sin_val, cos_val;

	logic signed [ik_pkg::WORD_W-1:0] col_x, col_y, end_x, end_y;
	logic col_valid, frame_start;

	ik_reg_file ik_reg_file_inst (
		.clk, .reset, .chipselect, .write, .address, .writedata,
		.target_x, .target_y, .damping, .joint_type, .theta, .length
	);

	jacobian_seq jacobian_seq_inst (
		.clk, .reset, .joint_type, .theta, .length,
		.sin_val, .cos_val, .trig_valid,
		.angle, .angle_valid,
		.col_x, .col_y, .col_valid, .frame_start,
		.publish(done), // done is the publish pulse
		.end_x, .end_y
	);

	sincos sincos_inst (
		.clk, .reset, .angle, .angle_valid,
		.sin_val, .cos_val, .trig_valid
	);

	jjt_accum jjt_accum_inst (
		.clk, .reset, .col_x, .col_y, .col_valid, .frame_start,
		.publish(done), .end_x, .end_y,
		.target_x, .target_y, .damping,
		.row_select, .col_select, .data
	);

endmodule

// File: rtl/jjt_accum.sv
//////////////////////////////////////////////////////////////////////
// Sums the 2x2 J*J^T over the Jacobian columns of a frame, latches
// the damped result and position error on publish, and serves the
// latched grid to the host through a registered row/column mux.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jjt_accum (
	input  logic clk,
	input  logic reset,

	input  logic signed [ik_pkg::WORD_W-1:0] col_x,
	input  logic signed [ik_pkg::WORD_W-1:0] col_y,
	input  logic col_valid,
	input  logic frame_start,
	input  logic publish,
	input  logic signed [ik_pkg::WORD_W-1:0] end_x,
	input  logic signed [ik_pkg::WORD_W-1:0] end_y,

	input  logic signed [ik_pkg::WORD_W-1:0] target_x,
	input  logic signed [ik_pkg::WORD_W-1:0] target_y,
	input  logic signed [ik_pkg::WORD_W-1:0] damping,

	input  logic [2:0] row_select,
	input  logic [2:0] col_select,
	output logic [ik_pkg::WORD_W-1:0] data
);

	logic signed [ik_pkg::WORD_W-1:0] sxx, sxy, syy;
	logic signed [ik_pkg::WORD_W-1:0] r_xx, r_xy, r_yy, err_x, err_y;

	always_ff @(posedge clk) begin
		if (reset) begin
			sxx   <= '0;
			sxy   <= '0;
			syy   <= '0;
			r_xx  <= '0;
			r_xy  <= '0;
			r_yy  <= '0;
			err_x <= '0;
			err_y <= '0;
			data  <= '0;
		end else begin
			if (frame_start) begin
				sxx <= '0;
				sxy <= '0;
				syy <= '0;
			end else if (col_valid) begin
				sxx <= sxx + ik_pkg::fx_mul(col_x, col_x);
				sxy <= sxy + ik_pkg::fx_mul(col_x, col_y);
				syy <= syy + ik_pkg::fx_mul(col_y, col_y);
			end

			// damping on the diagonal only
			if (publish) begin
				r_xx  <= sxx + damping;
				r_xy  <= sxy;
				r_yy  <= syy + damping;
				err_x <= target_x - end_x;
				err_y <= target_y - end_y;
			end

			case ({row_select, col_select})
				6'o00:        data <= r_xx;
				6'o01, 6'o10: data <= r_xy; // symmetric
				6'o11:        data <= r_yy;
				6'o20:        data <= err_x;
				6'o21:        data <= err_y;
				default:      data <= '0;
			endcase
		end
	end

endmodule

// File: rtl/jacobian_seq.sv
//////////////////////////////////////////////////////////////////////
// Frame sequencer. Pass 1 issues the cumulative joint angles to the
// sincos pipe and chains the joint positions out to the end effector.
// Pass 2 emits one Jacobian column every other cycle. A publish pulse
// on the last cycle hands the end effector to the accumulator.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jacobian_seq (
	input  logic clk,
	input  logic reset,

	input  logic [ik_pkg::NUM_JOINTS-1:0] joint_type,
	input  logic [ik_pkg::NUM_JOINTS-1:0][ik_pkg::WORD_W-1:0] theta,
	input  logic [ik_pkg::NUM_JOINTS-1:0][ik_pkg::WORD_W-1:0] length,

	input  logic signed [ik_pkg::WORD_W-1:0] sin_val,
	input  logic signed [ik_pkg::WORD_W-1:0] cos_val,
	input  logic trig_valid,

	output logic [ik_pkg::ANGLE_W-1:0] angle,
	output logic angle_valid,

	output logic signed [ik_pkg::WORD_W-1:0] col_x,
	output logic signed [ik_pkg::WORD_W-1:0] col_y,
	output logic col_valid,
	output logic frame_start,
	output logic publish,
	output logic signed [ik_pkg::WORD_W-1:0] end_x,
	output logic signed [ik_pkg::WORD_W-1:0] end_y
);

	logic [ik_pkg::FRAME_CNT_W-1:0] cnt, cnt_next, col_off;
	logic [2:0] issue_j, trig_j, col_j;
	logic issue, col_issue;

	// per-joint state captured in pass 1
	logic signed [ik_pkg::WORD_W-1:0] cos_j [ik_pkg::NUM_JOINTS];
	logic signed [ik_pkg::WORD_W-1:0] sin_j [ik_pkg::NUM_JOINTS];
	logic signed [ik_pkg::WORD_W-1:0] base_x [ik_pkg::NUM_JOINTS];
	logic signed [ik_pkg::WORD_W-1:0] base_y [ik_pkg::NUM_JOINTS];

	logic signed [ik_pkg::WORD_W-1:0] cur_x, cur_y, from_x, from_y;

	// outputs are registered, so decode against the cycle they appear in
	assign cnt_next = (cnt == ik_pkg::FRAME_LAST) ? '0 : cnt + 1'b1;

	assign issue   = (cnt_next < ik_pkg::PASS2_START) && (cnt_next[1:0] == 2'b00);
	assign issue_j = 3'(cnt_next >> 2);
	assign trig_j  = 3'(cnt >> 2); // result lands at 4i+2

	assign col_off   = cnt_next - ik_pkg::PASS2_START;
	assign col_j     = 3'(col_off >> 1);
	assign col_issue = (cnt_next >= ik_pkg::PASS2_START) && (cnt_next < ik_pkg::PASS2_END)
		&& !cnt_next[0];

	assign from_x = (trig_j == 3'd0) ? '0 : cur_x; // p_0 at origin
	assign from_y = (trig_j == 3'd0) ? '0 : cur_y;

	assign end_x = cur_x;
	assign end_y = cur_y;

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt         <= ik_pkg::FRAME_LAST; // next edge opens frame 0
			angle       <= '0;
			angle_valid <= 1'b0;
			col_valid   <= 1'b0;
			frame_start <= 1'b0;
			publish     <= 1'b0;
			cur_x       <= '0;
			cur_y       <= '0;
		end else begin
			cnt         <= cnt_next;
			frame_start <= (cnt_next == '0);
			publish     <= (cnt_next == ik_pkg::PUBLISH_CYCLE);
			angle_valid <= issue;
			col_valid   <= col_issue;

			// running sum wraps mod one turn
			if (issue)
				angle <= ((issue_j == 3'd0) ? '0 : angle)
					+ theta[issue_j][ik_pkg::ANGLE_W-1:0];

			if (trig_valid) begin
				cur_x <= from_x + ik_pkg::fx_mul(length[trig_j], cos_val);
				cur_y <= from_y + ik_pkg::fx_mul(length[trig_j], sin_val);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (trig_valid) begin
			cos_j[trig_j]  <= cos_val;
			sin_j[trig_j]  <= sin_val;
			base_x[trig_j] <= from_x;
			base_y[trig_j] <= from_y;
		end

		if (col_issue) begin
			if (joint_type[col_j]) begin
				// z cross (e - p_i)
				col_x <= base_y[col_j] - cur_y;
				col_y <= cur_x - base_x[col_j];
			end else begin
				col_x <= cos_j[col_j]; // slide along the link
				col_y <= sin_j[col_j];
			end
		end
	end

endmodule

// File: rtl/sincos.sv
//////////////////////////////////////////////////////////////////////
// Two-stage Q8 sine and cosine of a 10-bit binary angle. Stage 1
// scales the in-quadrant angle to radians and forms x^2, x^3; stage 2
// evaluates the Taylor polynomials and folds in the quadrant.
// Accepts one angle per cycle, results 2 cycles later.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sincos (
	input  logic clk,
	input  logic reset,

	input  logic [ik_pkg::ANGLE_W-1:0] angle,
	input  logic angle_valid,

	output logic signed [ik_pkg::WORD_W-1:0] sin_val,
	output logic signed [ik_pkg::WORD_W-1:0] cos_val,
	output logic trig_valid
);

	logic signed [ik_pkg::WORD_W-1:0] r_word;
	logic signed [ik_pkg::WORD_W-1:0] x_c, x2_c, x3_c;

	// stage 1 registers
	logic [1:0] quad1;
	logic signed [ik_pkg::WORD_W-1:0] x1, x2_1, x3_1;
	logic valid1;

	logic signed [ik_pkg::WORD_W-1:0] x4, x5, s_poly, c_poly;

	// low 8 bits are the angle within the quadrant
	assign r_word = {{(ik_pkg::WORD_W - ik_pkg::ANGLE_W + 2){1'b0}},
		angle[ik_pkg::ANGLE_W-3:0]};

	assign x_c  = ik_pkg::fx_mul(r_word, ik_pkg::HALF_PI_Q8); // to radians
	assign x2_c = ik_pkg::fx_mul(x_c, x_c);
	assign x3_c = ik_pkg::fx_mul(x2_c, x_c);

	always_ff @(posedge clk) begin
		if (reset)
			valid1 <= 1'b0;
		else
			valid1 <= angle_valid;
	end

	always_ff @(posedge clk) begin
		quad1 <= angle[ik_pkg::ANGLE_W-1 -: 2];
		x1    <= x_c;
		x2_1  <= x2_c;
		x3_1  <= x3_c;
	end

	assign x4 = ik_pkg::fx_mul(x3_1, x1);
	assign x5 = ik_pkg::fx_mul(x4, x1);

	assign s_poly = x1 - ik_pkg::fx_mul(x3_1, ik_pkg::INV6_Q8)
		+ ik_pkg::fx_mul(x5, ik_pkg::INV120_Q8);
	assign c_poly = ik_pkg::ONE_Q8 - (x2_1 >>> 1)
		+ ik_pkg::fx_mul(x4, ik_pkg::INV24_Q8);

	always_ff @(posedge clk) begin
		if (reset)
			trig_valid <= 1'b0;
		else
			trig_valid <= valid1;
	end

	always_ff @(posedge clk) begin
		case (quad1)
			2'd0: begin
				sin_val <= s_poly;
				cos_val <= c_poly;
			end
			2'd1: begin
				sin_val <= c_poly;
				cos_val <= -s_poly;
			end
			2'd2: begin
				sin_val <= -s_poly;
				cos_val <= -c_poly;
			end
			default: begin
				sin_val <= -c_poly;
				cos_val <= s_poly;
			end
		endcase
	end

endmodule

// File: rtl/ik_reg_file.sv
//////////////////////////////////////////////////////////////////////
// Parameter store for the IK accelerator. The host writes one byte
// per cycle; each 4-byte group fills a word top byte first, the top
// byte giving only 3 bits. All words are driven out continuously.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ik_reg_file (
	input  logic clk,
	input  logic reset,

	input  logic chipselect,
	input  logic write,
	input  logic [6:0] address,
	input  logic [7:0] writedata,

	output logic [ik_pkg::WORD_W-1:0] target_x,
	output logic [ik_pkg::WORD_W-1:0] target_y,
	output logic [ik_pkg::WORD_W-1:0] damping,
	output logic [ik_pkg::NUM_JOINTS-1:0] joint_type,
	output logic [ik_pkg::NUM_JOINTS-1:0][ik_pkg::WORD_W-1:0] theta,
	output logic [ik_pkg::NUM_JOINTS-1:0][ik_pkg::WORD_W-1:0] length
);

	logic [6:0] joint_off;
	logic [2:0] joint_sel;
	logic [2:0] joint_byte; // 0..3 theta, 4..7 length

	assign joint_off  = address - ik_pkg::ADDR_JOINT_BASE;
	assign joint_sel  = 3'(joint_off / ik_pkg::JOINT_STRIDE);
	assign joint_byte = 3'(joint_off % ik_pkg::JOINT_STRIDE);

	// replace one byte lane of a word
	function automatic logic [ik_pkg::WORD_W-1:0] put_byte(
		input logic [ik_pkg::WORD_W-1:0] word,
		input logic [1:0] lane,
		input logic [7:0] wd
	);
		logic [ik_pkg::WORD_W-1:0] w;
		w = word;
		case (lane)
			2'd0:    w[ik_pkg::WORD_W-1:24] = wd[2:0]; // only 3 bits land
			2'd1:    w[23:16] = wd;
			2'd2:    w[15:8] = wd;
			default: w[7:0] = wd;
		endcase
		return w;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			target_x   <= '0;
			target_y   <= '0;
			damping    <= '0;
			joint_type <= '0;
			theta      <= '0;
			length     <= '0;
		end else if (chipselect && write && address <= ik_pkg::ADDR_LAST) begin
			if (address < ik_pkg::ADDR_TARGET_Y)
				target_x <= put_byte(target_x, 2'(address - ik_pkg::ADDR_TARGET_X), writedata);
			else if (address < ik_pkg::ADDR_JOINT_TYPE)
				target_y <= put_byte(target_y, 2'(address - ik_pkg::ADDR_TARGET_Y), writedata);
			else if (address == ik_pkg::ADDR_JOINT_TYPE)
				joint_type <= writedata[ik_pkg::NUM_JOINTS-1:0];
			else if (address < ik_pkg::ADDR_JOINT_BASE)
				damping <= put_byte(damping, 2'(address - ik_pkg::ADDR_DAMPING), writedata);
			else if (joint_byte[2])
				length[joint_sel] <= put_byte(length[joint_sel], joint_byte[1:0], writedata);
			else
				theta[joint_sel] <= put_byte(theta[joint_sel], joint_byte[1:0], writedata);
		end
	end

endmodule

// File: rtl/ik_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared definitions for the planar IK accelerator: Q8 fixed-point
// format and multiply rule, host register map, sine/cosine polynomial
// constants and the frame schedule. Referenced by scoped name only.
//////////////////////////////////////////////////////////////////////

package ik_pkg;

	// signed fixed point with 8 fraction bits
	localparam int WORD_W     = 27;
	localparam int FRAC_W     = 8;
	localparam int NUM_JOINTS = 6;
	localparam int ANGLE_W    = 10; // 1024 units per turn

	localparam logic signed [WORD_W-1:0] ONE_Q8 = 27'sd256;

	// host register map, byte addressed
	localparam logic [6:0] ADDR_TARGET_X   = 7'd0;
	localparam logic [6:0] ADDR_TARGET_Y   = 7'd4;
	localparam logic [6:0] ADDR_JOINT_TYPE = 7'd8;
	localparam logic [6:0] ADDR_DAMPING    = 7'd9;
	localparam logic [6:0] ADDR_JOINT_BASE = 7'd13;
	localparam logic [6:0] JOINT_STRIDE    = 7'd8;  // theta then length
	localparam logic [6:0] ADDR_LAST       = 7'd60;

	// polynomial constants in Q8
	localparam logic signed [WORD_W-1:0] HALF_PI_Q8 = 27'sd402;
	localparam logic signed [WORD_W-1:0] INV6_Q8    = 27'sd43;
	localparam logic signed [WORD_W-1:0] INV24_Q8   = 27'sd11;
	localparam logic signed [WORD_W-1:0] INV120_Q8  = 27'sd2;

	// frame schedule
	localparam int FRAME_CYCLES = 48;
	localparam int FRAME_CNT_W  = $clog2(FRAME_CYCLES);
	localparam logic [FRAME_CNT_W-1:0] FRAME_LAST    = FRAME_CNT_W'(FRAME_CYCLES - 1);
	localparam logic [FRAME_CNT_W-1:0] PASS2_START   = 6'd24; // 4 cycles per joint before
	localparam logic [FRAME_CNT_W-1:0] PASS2_END     = 6'd36; // 2 cycles per column
	localparam logic [FRAME_CNT_W-1:0] PUBLISH_CYCLE = FRAME_LAST;

	// full product, arithmetic shift by FRAC_W, keep WORD_W bits
	function automatic logic signed [WORD_W-1:0] fx_mul(
		input logic signed [WORD_W-1:0] a,
		input logic signed [WORD_W-1:0] b
	);
		logic signed [2*WORD_W-1:0] prod;
		prod = a * b;
		return prod[FRAC_W +: WORD_W];
	endfunction

endpackage
